// File: sim/rom_matrix_patterns.txt
// columns: test  cmd  rom_addr  matrix_out  acc  error
// error bits are {bad device, accumulator, matrix}
1 1103 0018 83 00 0
1 1205 001d 3c 00 0
1 1100 0005 c4 00 0
1 1200 0000 0b 00 0
1 1205 0005 c4 00 0
1 1103 001d 3c 00 0
1 1107 003d dc 00 0
1 1207 003f 26 00 0
2 1108 0047 00 00 0
2 11ff 07ff 00 00 0
2 1100 0007 0e 00 0
2 1240 0040 00 00 0
2 1200 0000 0b 00 0
3 2100 0000 0b 0b 0
3 23f0 0000 0b fb 0
3 2200 0000 0b 06 0
3 1104 0020 ab 06 0
3 2200 0020 ab b1 0
3 2320 0020 ab d1 0
3 2100 0020 ab ab 0
3 2000 0020 ab ab 0
4 1201 0021 d0 ab 0
4 2100 0021 d0 d0 0
4 1202 0022 f5 d0 0
4 2200 0022 f5 c5 0
4 1100 0002 55 c5 0
4 2200 0002 55 1a 0
5 1f00 0000 0b 1a 1
5 1103 0000 0b 1a 1
5 2700 0000 0b 00 3
5 2305 0000 0b 00 3
5 5000 0000 0b 00 7
5 f123 0000 0b 00 7
6 0102 0000 0b 00 5
6 0000 0000 0b 00 5
6 2310 0000 0b 10 5
6 0104 0000 0b 10 1
6 0101 0000 0b 10 0
6 0000 0000 0b 10 0
6 1102 0010 5b 10 0
6 2200 0010 5b 6b 0
6 1300 0000 0b 6b 1
6 2f00 0000 0b 00 3
6 9000 0000 0b 00 7
6 0003 0000 0b 00 7
6 0107 0000 0b 00 0

// File: sources.f
source/rom_matrix_pkg.sv
source/rom_store.sv
source/rom_matrix.sv
source/acc_unit.sv
source/seq_control.sv
source/rom_matrix_system.sv
sim/rom_matrix_system_assert.sv
sim/tb_rom_matrix_system.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, result taken from the log

cd "$(dirname "$0")" || exit 1

top=tb_rom_matrix_system
log_file=sim.log

command -v verilator >/dev/null 2>&1
if [ $? -ne 0 ]; then
   echo "verilator not found in PATH"
   exit 1
fi

verilator --binary --timing --assert --top-module "$top" -f sources.f -o "$top"
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi

./obj_dir/"$top" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

grep -q "^Verification passed$" "$log_file"
if [ $? -ne 0 ]; then
   echo "no pass line found in $log_file"
   exit 1
fi

exit 0

// File: sim/tb_rom_matrix_system.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rom_matrix_system;

   localparam int num_patterns = 46;
   localparam int fields = 6; // test, cmd, rom_addr, matrix_out, acc, error
   localparam int num_tests = 6;
   localparam int half_period = 20;
   localparam int reset_cycles = 5;
   localparam int settle_limit = 10;
   localparam int pipe_depth = 2; // strobe edge to visible result

   logic clock;
   logic reset;
   logic [15:0] cmd;
   logic cmd_strobe;
   logic [15:0] rom_addr;
   logic [rom_matrix_pkg::data_width-1:0] matrix_out;
   logic [rom_matrix_pkg::data_width-1:0] acc;
   logic [2:0] error;

   logic [15:0] pattern_mem [num_patterns*fields];
   int error_count;
   int check_count;
   int test_errors [1:num_tests];
   int test_checks [1:num_tests];

   rom_matrix_system i_rom_matrix_system (
      .clock      (clock),
      .reset      (reset),
      .cmd        (cmd),
      .cmd_strobe (cmd_strobe),
      .rom_addr   (rom_addr),
      .matrix_out (matrix_out),
      .acc        (acc),
      .error      (error)
   );

   always #half_period clock = ~clock; // 40 ns period

   task automatic wait_cycles(input int count);
      for (int i = 0; i < count; i++) begin
         @(posedge clock);
      end
      #1;
   endtask

   task automatic check_value(input string name, input int test, input int idx,
                              input logic [15:0] got, input logic [15:0] exp);
      check_count++;
      test_checks[test]++;
      if (got !== exp) begin
         $display("ERR %s: got 0x%h, expected 0x%h (pattern %0d, cmd 0x%h)",
                  name, got, exp, idx, pattern_mem[idx*fields+1]);
         error_count++;
         test_errors[test]++;
      end
   endtask

   task automatic report_test(input int test);
      if (test_errors[test] == 0) begin
         $display("test %0d ok: %0d checks", test, test_checks[test]);
      end else begin
         $display("test %0d FAILED: %0d of %0d checks wrong", test, test_errors[test],
                  test_checks[test]);
      end
   endtask

   task automatic check_pattern(input int idx);
      int base;
      int test;
      base = idx * fields;
      test = int'(pattern_mem[base]);
      if (test < 1 || test > num_tests) begin
         $display("pattern %0d has no valid test number", idx);
         error_count++;
      end else begin
         check_value("rom_addr", test, idx, rom_addr, pattern_mem[base+2]);
         check_value("matrix_out", test, idx, 16'(matrix_out), pattern_mem[base+3]);
         check_value("acc", test, idx, 16'(acc), pattern_mem[base+4]);
         check_value("error", test, idx, 16'(error), pattern_mem[base+5]);
         // last pattern of a test group closes it
         if (idx == num_patterns - 1 || pattern_mem[base+fields] != pattern_mem[base]) begin
            report_test(test);
         end
      end
   endtask

   // hard limit on the whole run
   initial begin
      #(2 * half_period * 500);
      $display("timeout, the run did not reach its end");
      $display("Verification failed");
      $finish;
   end

   initial begin
      int settle;
      clock = 1'b0;
      reset = 1'b1;
      cmd = '0;
      cmd_strobe = 1'b0;
      error_count = 0;
      check_count = 0;
      for (int t = 1; t <= num_tests; t++) begin
         test_errors[t] = 0;
         test_checks[t] = 0;
      end
      $readmemh("sim/rom_matrix_patterns.txt", pattern_mem);
      if ($isunknown(pattern_mem[num_patterns*fields-1])) begin
         $display("pattern file is missing or shorter than expected");
         error_count++;
      end

      wait_cycles(reset_cycles);
      reset = 1'b0;

      settle = 0;
      while ((rom_addr !== '0 || acc !== '0 || error !== '0) && settle < settle_limit) begin
         wait_cycles(1);
         settle++;
      end
      if (settle == settle_limit) begin
         $display("outputs did not come out of reset as zero");
         error_count++;
      end
      wait_cycles(2); // devices leave their reset state

      // one word per cycle, result checked two edges after its strobe
      for (int t = 0; t < num_patterns + pipe_depth; t++) begin
         @(posedge clock);
         #1;
         if (t >= pipe_depth) begin
            check_pattern(t - pipe_depth);
         end
         if (t < num_patterns) begin
            cmd = pattern_mem[t*fields+1];
            cmd_strobe = 1'b1;
         end else begin
            cmd = '0;
            cmd_strobe = 1'b0;
         end
      end

      $display("%0d patterns, %0d checks, %0d errors", num_patterns, check_count, error_count);
      if (error_count == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sim/rom_matrix_system_assert.sv
`timescale 1ns/1ps
`default_nettype none

module rom_matrix_system_assert (
   input logic                      clock,
   input logic                      reset,
   input rom_matrix_pkg::cmd_word_t cmd,
   input logic                      cmd_strobe,
   input logic                      matrix_en,
   input logic                      acc_en,
   input logic                      clear_matrix,
   input logic                      clear_acc,
   input logic                      matrix_error,
   input logic [15:0]               rom_addr
);

   logic [3:0] pulses;
   logic is_matrix;
   logic is_acc;
   logic is_clear;

   assign pulses = {matrix_en, acc_en, clear_matrix, clear_acc};
   assign is_matrix = cmd.dev_view.dev == rom_matrix_pkg::dev_matrix;
   assign is_acc = cmd.dev_view.dev == rom_matrix_pkg::dev_acc;
   assign is_clear = cmd.sys_view.dev == rom_matrix_pkg::dev_system &&
                     cmd.sys_view.op == rom_matrix_pkg::sys_clear;

   // an enable only for the one device named by the strobed word
   single_enable: assert property (@(posedge clock) disable iff (reset)
      (matrix_en || acc_en) |-> $past(cmd_strobe) &&
         matrix_en == $past(is_matrix) && acc_en == $past(is_acc))
      else $error("enable raised for both devices or without its device word");

   error_addr_zero: assert property (@(posedge clock) disable iff (reset)
      matrix_error |-> rom_addr == 16'h0000)
      else $error("matrix device in error drives a nonzero rom_addr");

   matrix_dispatch: assert property (@(posedge clock) disable iff (reset)
      cmd_strobe && is_matrix |=> pulses == 4'b1000)
      else $error("matrix word not followed by matrix_en alone");

   acc_dispatch: assert property (@(posedge clock) disable iff (reset)
      cmd_strobe && is_acc |=> pulses == 4'b0100)
      else $error("accumulator word not followed by acc_en alone");

   clear_dispatch: assert property (@(posedge clock) disable iff (reset)
      cmd_strobe && is_clear |=>
         pulses == {2'b00, $past(cmd.sys_view.mask[0]), $past(cmd.sys_view.mask[1])})
      else $error("clear pulses do not match the clear mask");

   // idle cycles, sys_nop and unknown devices raise nothing
   quiet_dispatch: assert property (@(posedge clock) disable iff (reset)
      !(cmd_strobe && (is_matrix || is_acc || is_clear)) |=> pulses == 4'b0000)
      else $error("enable or clear pulse without a matching word");

endmodule

bind rom_matrix_system rom_matrix_system_assert i_rom_matrix_system_assert (
   .clock        (clock),
   .reset        (reset),
   .cmd          (cmd),
   .cmd_strobe   (cmd_strobe),
   .matrix_en    (matrix_en),
   .acc_en       (acc_en),
   .clear_matrix (clear_matrix),
   .clear_acc    (clear_acc),
   .matrix_error (matrix_error),
   .rom_addr     (rom_addr)
);

`default_nettype wire

// File: source/rom_matrix_system.sv
`timescale 1ns/1ps
`default_nettype none

module rom_matrix_system (
   input  logic                                clock,
   input  logic                                reset,
   input  logic [15:0]                         cmd,
   input  logic                                cmd_strobe,
   output logic [15:0]                         rom_addr,
   output logic [rom_matrix_pkg::data_width-1:0] matrix_out,
   output logic [rom_matrix_pkg::data_width-1:0] acc,
   output logic [2:0]                          error
);

   logic [11:0] inst;
   logic matrix_en;
   logic acc_en;
   logic clear_matrix;
   logic clear_acc;
   logic matrix_error;
   logic acc_error;
   logic [rom_matrix_pkg::data_width-1:0] rom_data;

   seq_control i_seq_control (
      .clock        (clock),
      .reset        (reset),
      .cmd          (cmd),
      .cmd_strobe   (cmd_strobe),
      .matrix_error (matrix_error),
      .acc_error    (acc_error),
      .inst         (inst),
      .matrix_en    (matrix_en),
      .acc_en       (acc_en),
      .clear_matrix (clear_matrix),
      .clear_acc    (clear_acc),
      .error        (error)
   );

   rom_matrix i_rom_matrix (
      .clock    (clock),
      .reset    (reset),
      .inst     (inst),
      .inst_en  (matrix_en),
      .clear    (clear_matrix),
      .rom_data (rom_data),
      .rom_addr (rom_addr),
      .out      (matrix_out),
      .error    (matrix_error)
   );

   rom_store i_rom_store (
      .addr (rom_addr),
      .data (rom_data)
   );

   // accumulator reads the byte the matrix device currently points at
   acc_unit i_acc_unit (
      .clock   (clock),
      .reset   (reset),
      .inst    (inst),
      .inst_en (acc_en),
      .clear   (clear_acc),
      .data    (matrix_out),
      .acc     (acc),
      .error   (acc_error)
   );

endmodule

`default_nettype wire

// File: source/seq_control.sv
`timescale 1ns/1ps
`default_nettype none

module seq_control (
   input  logic                      clock,
   input  logic                      reset,
   input  rom_matrix_pkg::cmd_word_t cmd,
   input  logic                      cmd_strobe,
   input  logic                      matrix_error,
   input  logic                      acc_error,
   output logic [11:0]               inst,
   output logic                      matrix_en,
   output logic                      acc_en,
   output logic                      clear_matrix,
   output logic                      clear_acc,
   output logic [2:0]                error
);

   rom_matrix_pkg::cmd_word_t cmd_q;
   logic strobe_q;
   logic bad_dev;
   logic bad_dev_flag;
   logic clear_seq;

   // host word capture, one cycle of dispatch latency
   always_ff @(posedge clock) begin
      if (reset) begin
         strobe_q <= 1'b0;
      end else begin
         strobe_q <= cmd_strobe;
      end
   end

   always_ff @(posedge clock) begin
      if (cmd_strobe) begin
         cmd_q <= cmd;
      end
   end

   assign inst = {cmd_q.dev_view.opcode, cmd_q.dev_view.imm};

   always_comb begin
      matrix_en = 1'b0;
      acc_en = 1'b0;
      clear_matrix = 1'b0;
      clear_acc = 1'b0;
      clear_seq = 1'b0;
      bad_dev = 1'b0;
      if (strobe_q) begin
         case (cmd_q.dev_view.dev)
            rom_matrix_pkg::dev_system: begin
               if (cmd_q.sys_view.op == rom_matrix_pkg::sys_clear) begin
                  clear_matrix = cmd_q.sys_view.mask[rom_matrix_pkg::clr_matrix_bit];
                  clear_acc = cmd_q.sys_view.mask[rom_matrix_pkg::clr_acc_bit];
                  clear_seq = cmd_q.sys_view.mask[rom_matrix_pkg::clr_seq_bit];
               end // sys_nop and others do nothing
            end
            rom_matrix_pkg::dev_matrix: begin
               matrix_en = 1'b1;
            end
            rom_matrix_pkg::dev_acc: begin
               acc_en = 1'b1;
            end
            default: begin
               bad_dev = 1'b1;
            end
         endcase
      end
   end

   // sticky until a sys_clear with mask bit 2
   always_ff @(posedge clock) begin
      if (reset) begin
         bad_dev_flag <= 1'b0;
      end else if (clear_seq) begin
         bad_dev_flag <= 1'b0;
      end else if (bad_dev) begin
         bad_dev_flag <= 1'b1;
      end
   end

   assign error = {bad_dev_flag, acc_error, matrix_error};

endmodule

`default_nettype wire

// File: source/acc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module acc_unit (
   input  logic                                clock,
   input  logic                                reset,
   input  logic [11:0]                         inst,
   input  logic                                inst_en,
   input  logic                                clear,
   input  logic [rom_matrix_pkg::data_width-1:0] data,
   output logic [rom_matrix_pkg::data_width-1:0] acc,
   output logic                                error
);

   logic [1:0] state;
   logic [3:0] opcode;
   logic [7:0] imm;

   assign opcode = inst[11:8];
   assign imm = inst[7:0];
   assign error = (state == rom_matrix_pkg::st_error);

   // sums wrap modulo 256
   always_ff @(posedge clock) begin
      if (reset || clear) begin
         state <= rom_matrix_pkg::st_reset;
         acc <= '0;
      end else begin
         case (state)
            rom_matrix_pkg::st_reset: begin
               state <= rom_matrix_pkg::st_ready;
            end
            rom_matrix_pkg::st_ready: begin
               if (inst_en) begin
                  case (opcode)
                     rom_matrix_pkg::op_nop: begin
                     end
                     rom_matrix_pkg::op_lda: begin
                        acc <= data; // byte from the matrix device
                     end
                     rom_matrix_pkg::op_add: begin
                        acc <= acc + data;
                     end
                     rom_matrix_pkg::op_adi: begin
                        acc <= acc + imm;
                     end
                     default: begin
                        state <= rom_matrix_pkg::st_error;
                        acc <= '0;
                     end
                  endcase
               end
            end
            rom_matrix_pkg::st_error: begin
               acc <= '0; // sticky
            end
            default: begin
               state <= rom_matrix_pkg::st_error;
               acc <= '0;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: source/rom_matrix.sv
`timescale 1ns/1ps
`default_nettype none

module rom_matrix (
   input  logic                                clock,
   input  logic                                reset,
   input  logic [11:0]                         inst,
   input  logic                                inst_en,
   input  logic                                clear,
   input  logic [rom_matrix_pkg::data_width-1:0] rom_data,
   output logic [15:0]                         rom_addr,
   output logic [rom_matrix_pkg::data_width-1:0] out,
   output logic                                error
);

   logic [1:0] state;
   logic [7:0] row;
   logic [7:0] col;
   logic [3:0] opcode;
   logic [7:0] imm;

   assign opcode = inst[11:8];
   assign imm = inst[7:0];

   // row-major linear address, may run past the table
   assign rom_addr = 16'(row * rom_matrix_pkg::rom_cols + col);
   assign out = rom_data;
   assign error = (state == rom_matrix_pkg::st_error);

   always_ff @(posedge clock) begin
      if (reset || clear) begin
         state <= rom_matrix_pkg::st_reset;
         row <= '0;
         col <= '0;
      end else begin
         case (state)
            rom_matrix_pkg::st_reset: begin
               state <= rom_matrix_pkg::st_ready; // one settling cycle
            end
            rom_matrix_pkg::st_ready: begin
               if (inst_en) begin
                  case (opcode)
                     rom_matrix_pkg::op_nop: begin
                     end
                     rom_matrix_pkg::op_ldr: begin
                        row <= imm;
                     end
                     rom_matrix_pkg::op_ldc: begin
                        col <= imm;
                     end
                     default: begin
                        state <= rom_matrix_pkg::st_error;
                        row <= '0;
                        col <= '0;
                     end
                  endcase
               end
            end
            rom_matrix_pkg::st_error: begin
               row <= '0; // held until clear
               col <= '0;
            end
            default: begin
               state <= rom_matrix_pkg::st_error;
               row <= '0;
               col <= '0;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: source/rom_store.sv
`timescale 1ns/1ps
`default_nettype none

module rom_store (
   input  logic [15:0]                         addr,
   output logic [rom_matrix_pkg::data_width-1:0] data
);

   logic [rom_matrix_pkg::data_width-1:0] rom_table [rom_matrix_pkg::rom_depth];

   // contents fixed by rom_byte
   for (genvar i = 0; i < rom_matrix_pkg::rom_depth; i++) begin : g_table
      assign rom_table[i] = rom_matrix_pkg::rom_byte(i);
   end

   always_comb begin
      if (addr < 16'(rom_matrix_pkg::rom_depth)) begin
         data = rom_table[addr[rom_matrix_pkg::rom_index_bits-1:0]];
      end else begin
         data = '0; // outside the matrix
      end
   end

endmodule

`default_nettype wire

// File: source/rom_matrix_pkg.sv
`default_nettype none

package rom_matrix_pkg;

   // matrix geometry
   localparam int rom_rows = 8;
   localparam int rom_cols = 8;
   localparam int rom_depth = rom_rows * rom_cols;
   localparam int rom_index_bits = $clog2(rom_depth);
   localparam int data_width = 8;

   // opcodes shared by both devices
   localparam logic [3:0] op_nop = 4'h0;

   // matrix device
   localparam logic [3:0] op_ldr = 4'h1;
   localparam logic [3:0] op_ldc = 4'h2;

   // accumulator device
   localparam logic [3:0] op_lda = 4'h1;
   localparam logic [3:0] op_add = 4'h2;
   localparam logic [3:0] op_adi = 4'h3;

   localparam logic [1:0] st_reset = 2'h0;
   localparam logic [1:0] st_ready = 2'h1;
   localparam logic [1:0] st_error = 2'h2;

   localparam logic [3:0] dev_system = 4'h0;
   localparam logic [3:0] dev_matrix = 4'h1;
   localparam logic [3:0] dev_acc = 4'h2;

   localparam logic [3:0] sys_nop = 4'h0;
   localparam logic [3:0] sys_clear = 4'h1;

   // bit positions in the sys_clear mask
   localparam int clr_matrix_bit = 0;
   localparam int clr_acc_bit = 1;
   localparam int clr_seq_bit = 2;

   typedef union packed {
      struct packed {
         logic [3:0] dev;
         logic [3:0] opcode;
         logic [7:0] imm;
      } dev_view;
      struct packed {
         logic [3:0] dev;
         logic [3:0] op;
         logic [7:0] mask;
      } sys_view;
   } cmd_word_t;

   // fixed rom contents, address * 37 + 11 truncated to a byte
   function automatic logic [data_width-1:0] rom_byte(input int unsigned addr);
      return data_width'(addr * 37 + 11);
   endfunction

endpackage

`default_nettype wire
